//--- rtl/f9mg_pkg.sv
`default_nettype none

package f9mg_pkg;

  // ------------------------------
  // message format sizes
  // ------------------------------
  localparam int BYTE_WIDTH            = 8;
  localparam int F9MG_CMD_LENGTH       = 12;
  localparam int F9DEV_NAME_LENGTH     = 6;
  localparam int F9DEV_SN_LENGTH       = 8;
  // local commands reuse the tail of the command field after the serial number
  localparam int F9MG_LOCAL_CMD_LENGTH = F9MG_CMD_LENGTH - F9DEV_SN_LENGTH;
  localparam int F9MG_ARG_MAX_LENGTH   = 64;
  localparam int F9MG_BUF_LENGTH       = F9MG_CMD_LENGTH + F9DEV_NAME_LENGTH
                                       + F9MG_ARG_MAX_LENGTH;
  // one extra count so an overlong message shows as 83
  localparam int W_F9MG_BUF_LEN        = $clog2(F9MG_BUF_LENGTH + 2);

  localparam int F9MG_CMD_WIDTH        = F9MG_CMD_LENGTH * BYTE_WIDTH;
  localparam int F9MG_BUF_WIDTH        = F9MG_BUF_LENGTH * BYTE_WIDTH;

  // ------------------------------
  // field types
  // ------------------------------
  typedef logic [F9MG_BUF_WIDTH-1:0]                 f9mg_buf_t;
  typedef logic [W_F9MG_BUF_LEN-1:0]                 f9mg_len_t;
  typedef logic [F9DEV_SN_LENGTH*BYTE_WIDTH-1:0]     f9dev_sn_t;
  typedef logic [F9DEV_NAME_LENGTH*BYTE_WIDTH-1:0]   f9dev_name_t;
  typedef logic [31:0]                               ip_addr_t;
  typedef logic [15:0]                               ip_port_t;
  typedef logic [47:0]                               mac_addr_t;

  // name, sn, group addr/port, src mac, src ip/port
  localparam int F9MG_SN_BUF_LENGTH = F9DEV_NAME_LENGTH + F9DEV_SN_LENGTH
                                    + ($bits(mac_addr_t)
                                    + 2 * ($bits(ip_addr_t) + $bits(ip_port_t)))
                                    / BYTE_WIDTH;
  localparam int F9MG_RESN_MSG_LENGTH = F9MG_CMD_LENGTH + F9MG_SN_BUF_LENGTH;

  typedef logic [F9MG_SN_BUF_LENGTH*BYTE_WIDTH-1:0]  f9mg_sn_buf_t;

  // decoded igmp action
  typedef logic [1:0] igmp_act_t;
  localparam igmp_act_t IGMP_ACT_IDLE  = 2'd0;
  localparam igmp_act_t IGMP_ACT_JOIN  = 2'd1;
  localparam igmp_act_t IGMP_ACT_LEAVE = 2'd2;
  localparam igmp_act_t IGMP_ACT_QUERY = 2'd3;

  // ------------------------------
  // command strings
  // ------------------------------
  localparam f9dev_name_t F9DEV_NAME_STRING = "f9pcap";
  localparam logic [F9MG_CMD_WIDTH-1:0] F9MG_CMD_RESN = "fonwin:resn:";
  localparam logic [F9MG_LOCAL_CMD_LENGTH*BYTE_WIDTH-1:0] F9MG_LOCAL_CMD_SGAP = "sgap";

endpackage

`default_nettype wire

//--- rtl/f9mg_msg_collector.sv
`timescale 1ns/10ps
`default_nettype none

module f9mg_msg_collector (
  input  wire logic             clk_in,
  input  wire logic             rst_in,
  input  wire logic             msg_valid,
  input  wire logic             msg_last,
  input  wire logic [7:0]       msg_data,
  output logic                  msg_done,
  output f9mg_pkg::f9mg_buf_t   msg_buf,
  output f9mg_pkg::f9mg_len_t   msg_len
);
  import f9mg_pkg::*;

  // length reported for anything longer than the buffer
  localparam f9mg_len_t LEN_OVERLONG = f9mg_len_t'(F9MG_BUF_LENGTH + 1);

  f9mg_buf_t buf_q;
  f9mg_buf_t buf_next;
  f9mg_len_t wr_pos;
  logic      msg_start;
  logic      done_q;

  // ------------------------------
  // byte placement
  // ------------------------------
  // byte 0 sits in the top byte of the buffer
  always_comb begin
    if (msg_start) begin
      buf_next = '0;
      buf_next[F9MG_BUF_WIDTH-1 -: BYTE_WIDTH] = msg_data;
    end else begin
      buf_next = buf_q;
      // bytes past the buffer end are dropped
      if (wr_pos < F9MG_BUF_LENGTH) begin
        buf_next[(F9MG_BUF_LENGTH - 1 - wr_pos) * BYTE_WIDTH +: BYTE_WIDTH] = msg_data;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (msg_valid) begin
      buf_q <= buf_next;
    end
  end

  // ------------------------------
  // position, start flag, done
  // ------------------------------
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      wr_pos    <= '0;
      msg_start <= 1'b1;
      done_q    <= 1'b0;
    end else begin
      done_q <= msg_valid & msg_last;
      if (msg_valid) begin
        // the byte after a last byte opens a new message
        msg_start <= msg_last;
        if (msg_start) begin
          wr_pos <= f9mg_len_t'(1);
        end else if (wr_pos < LEN_OVERLONG) begin
          wr_pos <= wr_pos + 1'b1;
        end
      end
    end
  end

  assign msg_done = done_q;
  assign msg_buf  = buf_q;
  assign msg_len  = wr_pos;

  // length stays saturated however many bytes arrive
  a_len_saturates: assert property (
    @(posedge clk_in) disable iff (rst_in)
    msg_len <= LEN_OVERLONG
  ) else $error("msg_len above saturation value");

endmodule

`default_nettype wire

//--- rtl/f9mg_cmd_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module f9mg_cmd_decoder #(
  parameter int SGAP_WIDTH = 32
) (
  input  wire logic                   clk_in,
  input  wire logic                   rst_in,
  input  wire logic                   msg_done,
  input  wire f9mg_pkg::f9mg_buf_t    msg_buf,
  input  wire f9mg_pkg::f9mg_len_t    msg_len,
  input  wire f9mg_pkg::f9dev_sn_t    f9dev_sn,
  output logic                        resn_write,
  output f9mg_pkg::f9mg_sn_buf_t      resn_data,
  output logic                        sgap_write,
  output logic [SGAP_WIDTH-1:0]       sgap_data
);
  import f9mg_pkg::*;

  // sgap argument is a whole number of bytes, big-endian
  localparam int SGAP_LENGTH   = (SGAP_WIDTH + BYTE_WIDTH - 1) / BYTE_WIDTH;
  localparam int SGAP_ALIGN_W  = SGAP_LENGTH * BYTE_WIDTH;
  // arguments follow the command field and the name slot
  localparam int ARG_OFFSET    = F9MG_CMD_LENGTH + F9DEV_NAME_LENGTH;
  localparam int LOCAL_CMD_W   = F9MG_LOCAL_CMD_LENGTH * BYTE_WIDTH;

  if (SGAP_WIDTH < 1 || SGAP_WIDTH > 32) begin : g_sgap_width_check
    $error("SGAP_WIDTH must be between 1 and 32");
  end

  logic [F9MG_CMD_WIDTH-1:0] cmd_str;
  f9dev_sn_t                 rx_sn;
  logic [LOCAL_CMD_W-1:0]    local_cmd;
  f9mg_len_t                 arg_len;
  logic [SGAP_ALIGN_W-1:0]   sgap_arg;
  f9mg_sn_buf_t              resn_arg;
  logic                      resn_hit;
  logic                      sgap_hit;

  // ------------------------------
  // field extraction
  // ------------------------------
  assign cmd_str = msg_buf[F9MG_BUF_WIDTH-1 -: F9MG_CMD_WIDTH];
  // local commands: sn in bytes 0-7, command word in bytes 8-11
  assign {rx_sn, local_cmd} = cmd_str;
  assign arg_len  = msg_len - f9mg_len_t'(ARG_OFFSET);
  assign sgap_arg = msg_buf[F9MG_BUF_WIDTH-1 - ARG_OFFSET*BYTE_WIDTH -: SGAP_ALIGN_W];
  assign resn_arg = msg_buf[F9MG_BUF_WIDTH-1 - F9MG_CMD_WIDTH -: $bits(f9mg_sn_buf_t)];

  // ------------------------------
  // command match
  // ------------------------------
  // resn needs the exact profile length, anything else is ignored
  assign resn_hit = msg_done
                 && (cmd_str == F9MG_CMD_RESN)
                 && (msg_len == F9MG_RESN_MSG_LENGTH);

  // sgap is only accepted for this device's serial number
  assign sgap_hit = msg_done
                 && (rx_sn == f9dev_sn)
                 && (local_cmd == F9MG_LOCAL_CMD_SGAP)
                 && (arg_len == f9mg_len_t'(SGAP_LENGTH));

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      resn_write <= 1'b0;
      sgap_write <= 1'b0;
    end else begin
      resn_write <= resn_hit;
      sgap_write <= sgap_hit;
    end
  end

  // argument capture, held until the next matching command
  always_ff @(posedge clk_in) begin
    if (resn_hit) begin
      resn_data <= resn_arg;
    end
    if (sgap_hit) begin
      sgap_data <= sgap_arg[SGAP_WIDTH-1:0];
    end
  end

  // the two command words cannot both match one message
  a_one_write: assert property (
    @(posedge clk_in) disable iff (rst_in)
    !(resn_write && sgap_write)
  ) else $error("resn_write and sgap_write asserted together");

endmodule

`default_nettype wire

//--- rtl/f9pcap_profile.sv
`timescale 1ns/10ps
`default_nettype none

module f9pcap_profile #(
  parameter int SGAP_WIDTH = 32
) (
  input  wire logic                   clk_in,
  input  wire logic                   rst_in,
  input  wire logic                   resn_write,
  input  wire f9mg_pkg::f9mg_sn_buf_t resn_data,
  input  wire logic                   sgap_write,
  input  wire logic [SGAP_WIDTH-1:0]  sgap_data,
  input  wire logic                   igmp_valid,
  input  wire f9mg_pkg::igmp_act_t    igmp_act,
  input  wire f9mg_pkg::ip_addr_t     igmp_group_addr,
  output logic                        is_f9pcap_en,
  output logic                        f9mg_rx_join,
  output f9mg_pkg::f9dev_sn_t         f9dev_sn,
  output logic [SGAP_WIDTH-1:0]       local_sgap,
  output f9mg_pkg::ip_addr_t          f9pcap_mcgroup_addr,
  output f9mg_pkg::ip_port_t          f9pcap_mcgroup_port,
  output f9mg_pkg::mac_addr_t         f9pcap_src_mac_addr,
  output f9mg_pkg::ip_addr_t          f9pcap_src_ip_addr,
  output f9mg_pkg::ip_port_t          f9pcap_src_port
);
  import f9mg_pkg::*;

  f9mg_sn_buf_t profile_q;
  f9dev_name_t  dev_name;
  logic         name_ok;
  logic         join_hit;

  // ------------------------------
  // stored profile and sgap
  // ------------------------------
  // profile is all zero until the first resn arrives
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      profile_q  <= '0;
      local_sgap <= '0;
    end else begin
      if (resn_write) begin
        profile_q <= resn_data;
      end
      if (sgap_write) begin
        local_sgap <= sgap_data;
      end
    end
  end

  // field order matches the resn payload, name first
  assign {dev_name,
          f9dev_sn,
          f9pcap_mcgroup_addr,
          f9pcap_mcgroup_port,
          f9pcap_src_mac_addr,
          f9pcap_src_ip_addr,
          f9pcap_src_port} = profile_q;

  assign name_ok = (dev_name == F9DEV_NAME_STRING);

  // ------------------------------
  // enable and igmp join
  // ------------------------------
  // join counts only for the group we were told to send to
  assign join_hit = igmp_valid
                 && (igmp_act == IGMP_ACT_JOIN)
                 && (igmp_group_addr == f9pcap_mcgroup_addr);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      is_f9pcap_en <= 1'b0;
      f9mg_rx_join <= 1'b0;
    end else begin
      is_f9pcap_en <= name_ok;
      f9mg_rx_join <= join_hit;
    end
  end

  // join pulse always traces back to a join strobe one cycle earlier
  a_join_follows_strobe: assert property (
    @(posedge clk_in) disable iff (rst_in)
    f9mg_rx_join |-> $past(igmp_valid && (igmp_act == IGMP_ACT_JOIN))
  ) else $error("f9mg_rx_join without a preceding igmp join");

endmodule

`default_nettype wire

//--- rtl/f9pcap_dev_f9mg.sv
`timescale 1ns/10ps
`default_nettype none

module f9pcap_dev_f9mg #(
  parameter int SGAP_WIDTH = 32
) (
  input  wire logic                   clk_in,
  input  wire logic                   rst_in,
  // management message bytes, udp payload only
  input  wire logic                   msg_valid,
  input  wire logic [7:0]             msg_data,
  input  wire logic                   msg_last,
  // decoded igmp
  input  wire logic                   igmp_valid,
  input  wire f9mg_pkg::igmp_act_t    igmp_act,
  input  wire f9mg_pkg::ip_addr_t     igmp_group_addr,
  output logic                        is_f9pcap_en,
  output logic                        f9mg_rx_join,
  output f9mg_pkg::f9dev_sn_t         f9dev_sn,
  output logic [SGAP_WIDTH-1:0]       local_sgap,
  output f9mg_pkg::ip_addr_t          f9pcap_mcgroup_addr,
  output f9mg_pkg::ip_port_t          f9pcap_mcgroup_port,
  output f9mg_pkg::mac_addr_t         f9pcap_src_mac_addr,
  output f9mg_pkg::ip_addr_t          f9pcap_src_ip_addr,
  output f9mg_pkg::ip_port_t          f9pcap_src_port
);
  import f9mg_pkg::*;

  logic                  msg_done;
  f9mg_buf_t             msg_buf;
  f9mg_len_t             msg_len;
  logic                  resn_write;
  f9mg_sn_buf_t          resn_data;
  logic                  sgap_write;
  logic [SGAP_WIDTH-1:0] sgap_data;

  // ------------------------------
  // collect -> decode -> store
  // ------------------------------
  f9mg_msg_collector u_collector (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .msg_valid (msg_valid),
    .msg_last  (msg_last),
    .msg_data  (msg_data),
    .msg_done  (msg_done),
    .msg_buf   (msg_buf),
    .msg_len   (msg_len)
  );

  f9mg_cmd_decoder #(
    .SGAP_WIDTH (SGAP_WIDTH)
  ) u_decoder (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .msg_done   (msg_done),
    .msg_buf    (msg_buf),
    .msg_len    (msg_len),
    .f9dev_sn   (f9dev_sn),
    .resn_write (resn_write),
    .resn_data  (resn_data),
    .sgap_write (sgap_write),
    .sgap_data  (sgap_data)
  );

  // stored sn feeds back to the decoder for local commands
  f9pcap_profile #(
    .SGAP_WIDTH (SGAP_WIDTH)
  ) u_profile (
    .clk_in              (clk_in),
    .rst_in              (rst_in),
    .resn_write          (resn_write),
    .resn_data           (resn_data),
    .sgap_write          (sgap_write),
    .sgap_data           (sgap_data),
    .igmp_valid          (igmp_valid),
    .igmp_act            (igmp_act),
    .igmp_group_addr     (igmp_group_addr),
    .is_f9pcap_en        (is_f9pcap_en),
    .f9mg_rx_join        (f9mg_rx_join),
    .f9dev_sn            (f9dev_sn),
    .local_sgap          (local_sgap),
    .f9pcap_mcgroup_addr (f9pcap_mcgroup_addr),
    .f9pcap_mcgroup_port (f9pcap_mcgroup_port),
    .f9pcap_src_mac_addr (f9pcap_src_mac_addr),
    .f9pcap_src_ip_addr  (f9pcap_src_ip_addr),
    .f9pcap_src_port     (f9pcap_src_port)
  );

endmodule

`default_nettype wire

//--- tb/tb_f9mg_model.svh
`ifndef TB_F9MG_MODEL_SVH
`define TB_F9MG_MODEL_SVH

// ------------------------------
// message format
// ------------------------------
localparam logic [95:0] RESN_CMD    = "fonwin:resn:";
localparam logic [31:0] SGAP_CMD    = "sgap";
localparam logic [47:0] NAME_F9PCAP = "f9pcap";
localparam int          RESN_LEN    = 44;
// sgap argument starts after sn, command word and name slot
localparam int          SGAP_ARG_AT = 18;
localparam int          SGAP_LEN    = SGAP_ARG_AT + 4;

logic [31:0]  lcg_state = 32'h88b4dc1e;
logic [7:0]   tx_msg [0:95];
int           tx_len;
// expected device state
logic [255:0] exp_profile;
logic [31:0]  exp_sgap;
logic         exp_en;
int           exp_joins;

function automatic logic [31:0] next_random();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// upper lcg bits, the low ones repeat too quickly
function automatic int random_below(input int n);
  return int'(next_random() >> 16) % n;
endfunction

// name, sn, group addr, group port, src mac, src ip, src port
function automatic logic [255:0] random_profile(input bit f9_name);
  logic [255:0] prof;
  for (int k = 0; k < 8; k++) begin
    prof[k*32 +: 32] = next_random();
  end
  if (f9_name) begin
    prof[255:208] = NAME_F9PCAP;
  end
  return prof;
endfunction

// ------------------------------
// message builders
// ------------------------------
function automatic void build_resn(input logic [255:0] prof, input int len);
  tx_len = len;
  for (int i = 0; i < len; i++) begin
    if (i < 12) begin
      tx_msg[i] = RESN_CMD[95 - 8*i -: 8];
    end else if (i < RESN_LEN) begin
      tx_msg[i] = prof[255 - 8*(i-12) -: 8];
    end else begin
      tx_msg[i] = 8'(next_random());
    end
  end
endfunction

function automatic void build_sgap(input logic [63:0] sn, input logic [31:0] value,
                                   input int arg_len);
  tx_len = SGAP_ARG_AT + arg_len;
  for (int i = 0; i < tx_len; i++) begin
    if (i < 8) begin
      tx_msg[i] = sn[63 - 8*i -: 8];
    end else if (i < 12) begin
      tx_msg[i] = SGAP_CMD[31 - 8*(i-8) -: 8];
    end else if (i < SGAP_ARG_AT || i >= SGAP_LEN) begin
      tx_msg[i] = 8'(next_random());
    end else begin
      tx_msg[i] = value[31 - 8*(i-SGAP_ARG_AT) -: 8];
    end
  end
endfunction

function automatic void build_random(input int len);
  tx_len = len;
  for (int i = 0; i < len; i++) begin
    tx_msg[i] = 8'(next_random());
  end
endfunction

// flips one letter case somewhere in the command field
function automatic void corrupt_command();
  int pos;
  pos = random_below(12);
  tx_msg[pos] = tx_msg[pos] ^ 8'h20;
endfunction

// ------------------------------
// reference model
// ------------------------------
function automatic void model_message();
  logic [95:0]  cmd;
  logic [255:0] prof;
  logic [31:0]  arg;
  cmd  = '0;
  prof = '0;
  arg  = '0;
  for (int i = 0; i < 12; i++) begin
    cmd = {cmd[87:0], tx_msg[i]};
  end
  if (tx_len == RESN_LEN && cmd == RESN_CMD) begin
    for (int i = 12; i < RESN_LEN; i++) begin
      prof = {prof[247:0], tx_msg[i]};
    end
    exp_profile = prof;
  end else if (tx_len == SGAP_LEN && cmd[95:32] == exp_profile[207:144]
               && cmd[31:0] == SGAP_CMD) begin
    for (int i = SGAP_ARG_AT; i < SGAP_LEN; i++) begin
      arg = {arg[23:0], tx_msg[i]};
    end
    exp_sgap = arg;
  end
  exp_en = (exp_profile[255:208] == NAME_F9PCAP);
endfunction

// only a join for the stored group counts
function automatic bit join_expected(input logic [1:0] act, input logic [31:0] group);
  return (act == 2'd1) && (group == exp_profile[143:112]);
endfunction

`endif

//--- tb/tb_f9pcap_dev_f9mg.sv
`timescale 1ns/10ps
`default_nettype none

module tb_f9pcap_dev_f9mg;

  localparam int SGAP_WIDTH     = 32;
  // last byte drive edge to the cycle where the enable has settled, plus one spare
  localparam int CHECK_DELAY    = 6;
  localparam int N_DIRECTED     = 16;
  localparam int N_RANDOM       = 24;
  localparam int MAX_MSG_LEN    = 90;
  // worst case per item: a gap before every byte, an idle tail and one igmp event
  localparam int TIMEOUT_CYCLES = (N_DIRECTED + N_RANDOM) * (2 * MAX_MSG_LEN + 12);

  logic        clk_in;
  logic        rst_in;
  logic        msg_valid;
  logic [7:0]  msg_data;
  logic        msg_last;
  logic        igmp_valid;
  logic [1:0]  igmp_act;
  logic [31:0] igmp_group_addr;
  logic        is_f9pcap_en;
  logic        f9mg_rx_join;
  logic [63:0] f9dev_sn;
  logic [31:0] local_sgap;
  logic [31:0] f9pcap_mcgroup_addr;
  logic [15:0] f9pcap_mcgroup_port;
  logic [47:0] f9pcap_src_mac_addr;
  logic [31:0] f9pcap_src_ip_addr;
  logic [15:0] f9pcap_src_port;

  int cycle_count = 0;
  int seen_joins  = 0;
  int checks_done = 0;
  int due_q [$];

  `include "tb_f9mg_model.svh"

  f9pcap_dev_f9mg #(
    .SGAP_WIDTH (SGAP_WIDTH)
  ) u_f9pcap_dev_f9mg (.*);

  initial begin
    clk_in = 1'b0;
    forever #20 clk_in = ~clk_in;
  end

  always @(posedge clk_in) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Result: FAILED");
      $fatal(1);
    end
  end

  // ------------------------------
  // comparison
  // ------------------------------
  task automatic check_field(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      $display("Result: FAILED");
      $fatal(1);
    end
  endtask

  task automatic compare_outputs();
    check_field("is_f9pcap_en", is_f9pcap_en, exp_en);
    check_field("f9dev_sn", f9dev_sn, exp_profile[207:144]);
    check_field("f9pcap_mcgroup_addr", f9pcap_mcgroup_addr, exp_profile[143:112]);
    check_field("f9pcap_mcgroup_port", f9pcap_mcgroup_port, exp_profile[111:96]);
    check_field("f9pcap_src_mac_addr", f9pcap_src_mac_addr, exp_profile[95:48]);
    check_field("f9pcap_src_ip_addr", f9pcap_src_ip_addr, exp_profile[47:16]);
    check_field("f9pcap_src_port", f9pcap_src_port, exp_profile[15:0]);
    check_field("local_sgap", local_sgap, exp_sgap);
    check_field("f9mg_rx_join pulse count", seen_joins, exp_joins);
    checks_done++;
  endtask

  // sampled mid-cycle, away from the driving edge
  always @(negedge clk_in) begin
    if (!rst_in && f9mg_rx_join === 1'b1) begin
      seen_joins++;
    end
    while (due_q.size() > 0 && due_q[0] <= cycle_count) begin
      void'(due_q.pop_front());
      compare_outputs();
    end
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk_in);
      msg_valid  <= 1'b0;
      msg_last   <= 1'b0;
      igmp_valid <= 1'b0;
    end
  endtask

  task automatic send_message(input bit gapped);
    for (int i = 0; i < tx_len; i++) begin
      if (gapped && random_below(2) == 0) begin
        idle_cycles(1);
      end
      @(posedge clk_in);
      msg_valid <= 1'b1;
      msg_data  <= tx_msg[i];
      msg_last  <= (i == tx_len - 1);
    end
    model_message();
    due_q.push_back(cycle_count + CHECK_DELAY);
  endtask

  // idle first so the profile has settled before the strobe
  task automatic send_igmp(input logic [1:0] act, input logic [31:0] group);
    idle_cycles(CHECK_DELAY);
    @(posedge clk_in);
    igmp_valid      <= 1'b1;
    igmp_act        <= act;
    igmp_group_addr <= group;
    if (join_expected(act, group)) begin
      exp_joins++;
    end
    due_q.push_back(cycle_count + CHECK_DELAY);
    idle_cycles(1);
  endtask

  initial begin
    logic [255:0] base;
    logic [255:0] prof;
    int           kind;
    rst_in          = 1'b1;
    msg_valid       = 1'b0;
    msg_data        = 8'h00;
    msg_last        = 1'b0;
    igmp_valid      = 1'b0;
    igmp_act        = 2'd0;
    igmp_group_addr = 32'h0;
    exp_profile     = '0;
    exp_sgap        = '0;
    exp_en          = 1'b0;
    exp_joins       = 0;
    repeat (2) @(posedge clk_in);
    rst_in <= 1'b0;
    due_q.push_back(cycle_count + 2);

    // profile load, then malformed resn that must be ignored
    base = random_profile(1'b1);
    build_resn(base, RESN_LEN);
    send_message(1'b0);
    build_resn(random_profile(1'b1), RESN_LEN - 1);
    send_message(1'b0);
    build_resn(random_profile(1'b1), RESN_LEN + 1);
    send_message(1'b1);
    build_resn(random_profile(1'b1), RESN_LEN);
    corrupt_command();
    send_message(1'b0);
    idle_cycles(CHECK_DELAY);
    prof = random_profile(1'b0);
    prof[255:208] = "f9pcaq";
    build_resn(prof, RESN_LEN);
    send_message(1'b1);
    build_resn(base, RESN_LEN);
    send_message(1'b0);

    // sgap with good and bad sn or length
    build_sgap(exp_profile[207:144], next_random(), 4);
    send_message(1'b0);
    build_sgap(exp_profile[207:144] ^ 64'h1, next_random(), 4);
    send_message(1'b1);
    build_sgap(exp_profile[207:144], next_random(), 3);
    send_message(1'b0);
    build_sgap(exp_profile[207:144], next_random(), 5);
    send_message(1'b0);

    // igmp join, other group, leave, query
    send_igmp(2'd1, exp_profile[143:112]);
    send_igmp(2'd1, exp_profile[143:112] ^ 32'h1);
    send_igmp(2'd2, exp_profile[143:112]);
    send_igmp(2'd3, exp_profile[143:112]);

    for (int m = 0; m < N_RANDOM; m++) begin
      kind = random_below(8);
      case (kind)
        0: build_resn(random_profile(random_below(4) != 0), RESN_LEN);
        1: build_sgap(exp_profile[207:144], next_random(), 4);
        2: build_sgap(exp_profile[207:144] ^ {32'h0, next_random() | 32'h1}, next_random(), 4);
        3: build_sgap(exp_profile[207:144], next_random(), 3 + 2 * random_below(2));
        4: build_resn(random_profile(1'b1), RESN_LEN - 1 + 2 * random_below(2));
        5: begin
          build_resn(random_profile(1'b1), RESN_LEN);
          corrupt_command();
        end
        // overlong, length saturates and nothing matches
        6: build_resn(random_profile(1'b1), 83 + random_below(MAX_MSG_LEN - 82));
        default: build_random(1 + random_below(20));
      endcase
      send_message(random_below(2) == 0);
      if (random_below(3) == 0) begin
        idle_cycles(random_below(4));
      end
      if (random_below(4) == 0) begin
        send_igmp(2'(random_below(4)),
                  random_below(2) == 0 ? exp_profile[143:112] : next_random());
      end
    end

    idle_cycles(CHECK_DELAY + 2);
    if (due_q.size() == 0 && checks_done > 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("Run ended with %0d checks never performed", due_q.size());
      $display("Result: FAILED");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+tb
rtl/f9mg_pkg.sv
rtl/f9mg_msg_collector.sv
rtl/f9mg_cmd_decoder.sv
rtl/f9pcap_profile.sv
rtl/f9pcap_dev_f9mg.sv
tb/tb_f9pcap_dev_f9mg.sv
